//--- source/jac_types_pkg.sv
// data types shared by every stage of the matrix engine.
// all widths are exact for 3x3 signed 9-bit operands, so nothing saturates.
`default_nettype none

package jac_types_pkg;

	localparam int DIM   = 3;         // matrix order.
	localparam int LANES = DIM * DIM; // one multiplier lane per element.

	typedef logic signed [8:0]  elem_t; // input element.
	typedef logic signed [17:0] prod_t; // elem_t x elem_t.
	typedef logic signed [19:0] acc_t;  // sum of three prod_t.
	typedef logic signed [28:0] out_t;  // acc_t x elem_t.

	// one column of A or one row of B, el[0] is the top or left element.
	typedef struct packed {
		elem_t [DIM-1:0] el;
	} vec3_t;

	// row-major, element (r, c) sits at el[r*3 + c].
	typedef struct packed {
		elem_t [LANES-1:0] el;
	} mat_elem_t;

	typedef struct packed {
		acc_t [LANES-1:0] el;
	} mat_acc_t;

	typedef struct packed {
		out_t [LANES-1:0] el;
	} mat_out_t;

	// one outer-product step, column k of A against row k of B.
	typedef struct packed {
		vec3_t a_col;
		vec3_t b_row;
		logic  first; // step 0, accumulator loads.
		logic  last;  // step 2, result complete after this one.
	} step_t;

endpackage

`default_nettype wire

//--- source/jac_ctrl_pkg.sv
// sequencing constants for the controller and the pipeline stages.
// LATENCY is counted in enabled cycles and follows from the depths below.
`default_nettype none

package jac_ctrl_pkg;

	localparam int STEPS      = 3; // outer-product steps per job.
	localparam int MULT_DEPTH = 1; // register stages inside mult_array.

	// steps, then the lane products, the accumulator and the weighting stage.
	localparam int LATENCY = STEPS + MULT_DEPTH + 1 + MULT_DEPTH;

	typedef logic [$clog2(STEPS)-1:0] step_idx_t;

endpackage

`default_nettype wire

//--- source/mult_array.sv
// nine signed multipliers with one output register, held while en is low.
// the product type must be wide enough for the full product of its operands.
`timescale 1ns/1ps
`default_nettype none

module mult_array #(
	parameter type a_el_t = logic signed [8:0],
	parameter type b_el_t = logic signed [8:0],
	parameter type p_el_t = logic signed [17:0]
) (
	input  logic          clk,
	input  logic          en,
	input  a_el_t [8:0]   a,
	input  b_el_t [8:0]   b,
	output p_el_t [8:0]   p
);

	p_el_t [8:0] prod;

	// operands are widened first so each product is exact.
	always_comb begin
		for (int i = 0; i < 9; i++) begin
			prod[i] = p_el_t'(a[i]) * p_el_t'(b[i]);
		end
	end

	// no reset here, lanes only carry data.
	always_ff @(posedge clk) begin
		if (en) begin
			p <= prod;
		end
	end

endmodule

`default_nettype wire

//--- source/jacobian_ctrl.sv
// takes one job per start and issues its three outer-product steps.
// a start is dropped while steps are going out, except on the last step.
`timescale 1ns/1ps
`default_nettype none

module jacobian_ctrl (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  en,
	input  logic                  start,
	input  jac_types_pkg::mat_elem_t a,
	input  jac_types_pkg::mat_elem_t b,
	input  jac_types_pkg::mat_elem_t w,
	output jac_types_pkg::step_t     step,
	output logic                  step_valid,
	output jac_types_pkg::mat_elem_t w_out
);

	jac_types_pkg::mat_elem_t a_q;
	jac_types_pkg::mat_elem_t b_q;
	jac_types_pkg::mat_elem_t w_q;
	jac_types_pkg::step_t     step_next;
	jac_ctrl_pkg::step_idx_t  cnt;      // step issued on the next enabled edge.
	logic                     busy;
	logic                     last_step;
	logic                     accept;

	assign last_step = busy && (cnt == jac_ctrl_pkg::step_idx_t'(jac_ctrl_pkg::STEPS - 1));

	// the only busy decision, back-to-back allowed on the last step.
	assign accept = start && (!busy || last_step);

	// column cnt of A, row cnt of B.
	always_comb begin
		for (int i = 0; i < jac_types_pkg::DIM; i++) begin
			step_next.a_col.el[i] = a_q.el[i*jac_types_pkg::DIM + int'(cnt)];
			step_next.b_row.el[i] = b_q.el[int'(cnt)*jac_types_pkg::DIM + i];
		end
		step_next.first = (cnt == '0);
		step_next.last  = last_step;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy       <= 1'b0;
			cnt        <= '0;
			step_valid <= 1'b0;
		end else if (en) begin
			step_valid <= busy;
			if (accept) begin
				busy <= 1'b1;
				cnt  <= '0;
			end else if (last_step) begin
				busy <= 1'b0; // job fully issued.
				cnt  <= '0;
			end else if (busy) begin
				cnt <= cnt + 1'b1;
			end
		end
	end

	// job capture and step registers.
	always_ff @(posedge clk) begin
		if (en) begin
			if (accept) begin
				a_q <= a;
				b_q <= b;
				w_q <= w;
			end
			if (busy) begin
				step  <= step_next;
				w_out <= w_q; // old job's W, even when a new one is captured.
			end
		end
	end

endmodule

`default_nettype wire

//--- source/mat_mult.sv
// accumulates three outer products into C = A x B, one step per strobe.
// expects steps of a job on consecutive enabled cycles, first through last.
`timescale 1ns/1ps
`default_nettype none

module mat_mult #(
	parameter type payload_t = jac_types_pkg::mat_elem_t
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  en,
	input  jac_types_pkg::step_t     step,
	input  logic                  step_valid,
	input  payload_t              payload,
	output jac_types_pkg::mat_acc_t  c,
	output payload_t              payload_out,
	output logic                  c_valid
);

	localparam int D = jac_ctrl_pkg::MULT_DEPTH;

	jac_types_pkg::elem_t [8:0] lane_a;
	jac_types_pkg::elem_t [8:0] lane_b;
	jac_types_pkg::prod_t [8:0] prod;

	logic [D-1:0] valid_sr;
	logic [D-1:0] first_sr;
	logic [D-1:0] last_sr;
	payload_t     pay_sr [D];

	// lane i*3+j gets a_col[i] and b_row[j].
	always_comb begin
		for (int i = 0; i < jac_types_pkg::DIM; i++) begin
			for (int j = 0; j < jac_types_pkg::DIM; j++) begin
				lane_a[i*jac_types_pkg::DIM + j] = step.a_col.el[i];
				lane_b[i*jac_types_pkg::DIM + j] = step.b_row.el[j];
			end
		end
	end

	mult_array #(
		.a_el_t(jac_types_pkg::elem_t),
		.b_el_t(jac_types_pkg::elem_t),
		.p_el_t(jac_types_pkg::prod_t)
	) u_mult (
		.clk(clk),
		.en (en),
		.a  (lane_a),
		.b  (lane_b),
		.p  (prod)
	);

	// step flags follow the products through the lanes.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid_sr <= '0;
			c_valid  <= 1'b0;
		end else if (en) begin
			valid_sr[0] <= step_valid;
			for (int k = 1; k < D; k++) begin
				valid_sr[k] <= valid_sr[k-1];
			end
			c_valid <= valid_sr[D-1] && last_sr[D-1];
		end
	end

	always_ff @(posedge clk) begin
		if (en) begin
			first_sr[0] <= step.first;
			last_sr[0]  <= step.last;
			pay_sr[0]   <= payload;
			for (int k = 1; k < D; k++) begin
				first_sr[k] <= first_sr[k-1];
				last_sr[k]  <= last_sr[k-1];
				pay_sr[k]   <= pay_sr[k-1];
			end
			if (valid_sr[D-1]) begin
				for (int n = 0; n < jac_types_pkg::LANES; n++) begin
					if (first_sr[D-1]) begin
						c.el[n] <= jac_types_pkg::acc_t'(prod[n]); // load on first.
					end else begin
						c.el[n] <= c.el[n] + jac_types_pkg::acc_t'(prod[n]);
					end
				end
				if (last_sr[D-1]) begin
					payload_out <= pay_sr[D-1];
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- source/array_mult.sv
// weights each element of C by the matching element of W.
// c and w are sampled on the edge after c_valid, then held by mat_mult.
`timescale 1ns/1ps
`default_nettype none

module array_mult (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  en,
	input  jac_types_pkg::mat_acc_t  c,
	input  jac_types_pkg::mat_elem_t w,
	input  logic                  c_valid,
	output jac_types_pkg::mat_out_t  result,
	output logic                  done
);

	localparam int D = jac_ctrl_pkg::MULT_DEPTH;

	logic [D-1:0] valid_sr;

	// the lane register is the result register.
	mult_array #(
		.a_el_t(jac_types_pkg::acc_t),
		.b_el_t(jac_types_pkg::elem_t),
		.p_el_t(jac_types_pkg::out_t)
	) u_mult (
		.clk(clk),
		.en (en),
		.a  (c.el),
		.b  (w.el),
		.p  (result.el)
	);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid_sr <= '0;
		end else if (en) begin
			valid_sr[0] <= c_valid;
			for (int k = 1; k < D; k++) begin
				valid_sr[k] <= valid_sr[k-1];
			end
		end
	end

	assign done = valid_sr[D-1]; // one enabled cycle per job.

endmodule

`default_nettype wire

//--- source/jacobian_top.sv
// R = (A x B) .* W, done pulses jac_ctrl_pkg::LATENCY enabled cycles after start.
// en low freezes the whole pipeline, including done.
`timescale 1ns/1ps
`default_nettype none

module jacobian_top (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  en,
	input  logic                  start,
	input  jac_types_pkg::mat_elem_t a,
	input  jac_types_pkg::mat_elem_t b,
	input  jac_types_pkg::mat_elem_t w,
	output jac_types_pkg::mat_out_t  result,
	output logic                  done
);

	jac_types_pkg::step_t     step;
	logic                     step_valid;
	jac_types_pkg::mat_elem_t w_step; // W beside the last step.
	jac_types_pkg::mat_acc_t  c;
	jac_types_pkg::mat_elem_t w_c;    // W beside the finished C.
	logic                     c_valid;

	jacobian_ctrl u_ctrl (
		.clk       (clk),
		.rst_n     (rst_n),
		.en        (en),
		.start     (start),
		.a         (a),
		.b         (b),
		.w         (w),
		.step      (step),
		.step_valid(step_valid),
		.w_out     (w_step)
	);

	mat_mult #(
		.payload_t(jac_types_pkg::mat_elem_t)
	) u_mat_mult (
		.clk        (clk),
		.rst_n      (rst_n),
		.en         (en),
		.step       (step),
		.step_valid (step_valid),
		.payload    (w_step),
		.c          (c),
		.payload_out(w_c),
		.c_valid    (c_valid)
	);

	array_mult u_array_mult (
		.clk    (clk),
		.rst_n  (rst_n),
		.en     (en),
		.c      (c),
		.w      (w_c),
		.c_valid(c_valid),
		.result (result),
		.done   (done)
	);

endmodule

`default_nettype wire

//--- tb/jacobian_model.svh
// reference model, random source and value check for the matrix engine testbench.
// included inside the testbench module and shares its scope.
`ifndef JACOBIAN_MODEL_SVH
`define JACOBIAN_MODEL_SVH

	logic [31:0] lcg_state = 32'heca751c9;
	int          checks    = 0;
	int          errors    = 0;

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// upper bits only, the low ones repeat too soon.
	function automatic int rand_below(input int n);
		logic [31:0] r;
		r = lcg_next();
		return int'(r[31:16]) % n;
	endfunction

	function automatic jac_types_pkg::mat_elem_t rand_mat();
		jac_types_pkg::mat_elem_t m;
		logic [31:0]              r;
		for (int i = 0; i < 9; i++) begin
			r = lcg_next();
			m.el[i] = jac_types_pkg::elem_t'(r[31:23]); // full signed range.
		end
		return m;
	endfunction

	function automatic jac_types_pkg::mat_elem_t fill_mat(input int v);
		jac_types_pkg::mat_elem_t m;
		for (int i = 0; i < 9; i++) begin
			m.el[i] = jac_types_pkg::elem_t'(v);
		end
		return m;
	endfunction

	// R = (A x B) .* W in plain integers, row-major.
	function automatic jac_types_pkg::mat_out_t model_result(
		input jac_types_pkg::mat_elem_t ma,
		input jac_types_pkg::mat_elem_t mb,
		input jac_types_pkg::mat_elem_t mw
	);
		jac_types_pkg::mat_out_t r;
		int                      sum;
		for (int i = 0; i < 3; i++) begin
			for (int j = 0; j < 3; j++) begin
				sum = 0;
				for (int k = 0; k < 3; k++) begin
					sum += int'(ma.el[i*3 + k]) * int'(mb.el[k*3 + j]);
				end
				r.el[i*3 + j] = jac_types_pkg::out_t'(sum * int'(mw.el[i*3 + j]));
			end
		end
		return r;
	endfunction

	task automatic check_value(input logic signed [63:0] got,
		input logic signed [63:0] expected, input string what);
		checks++;
		if (got !== expected) begin
			errors++;
			$display("** Error at %0t: %s, got %0d, expected %0d", $time, what, got, expected);
		end
	endtask

`endif

//--- tb/jacobian_tb.sv
// random jobs against the integer model, en stalls included.
// inputs change 0.5 ns after each rising edge; outputs are read at the same point.
`timescale 1ns/1ps
`default_nettype none

module jacobian_tb;

	logic                     clk = 1'b0;
	logic                     rst_n;
	logic                     en;
	logic                     start;
	jac_types_pkg::mat_elem_t a;
	jac_types_pkg::mat_elem_t b;
	jac_types_pkg::mat_elem_t w;
	jac_types_pkg::mat_out_t  result;
	logic                     done;

	jac_types_pkg::mat_out_t  exp_q[$];  // expected R of each accepted job.
	int                       edge_q[$]; // enabled edge that accepted it.
	jac_types_pkg::mat_elem_t job_a;
	jac_types_pkg::mat_elem_t job_b;
	jac_types_pkg::mat_elem_t job_w;
	int en_edges   = 0;
	int pending    = 0; // steps the controller still has to issue.
	int accepted   = 0;
	int done_count = 0;
	int err_base   = 0;

	`include "jacobian_model.svh"

	jacobian_top dut_i (
		.clk   (clk),
		.rst_n (rst_n),
		.en    (en),
		.start (start),
		.a     (a),
		.b     (b),
		.w     (w),
		.result(result),
		.done  (done)
	);

	always #2 clk = ~clk;

	task automatic pick_job();
		job_a = rand_mat();
		job_b = rand_mat();
		job_w = rand_mat();
	endtask

	function automatic logic pick_en(input int low_pct);
		return rand_below(100) >= low_pct;
	endfunction

	task automatic check_done();
		jac_types_pkg::mat_out_t exp_r;
		int                      acc_edge;
		if (exp_q.size() == 0) begin
			$display("unexpected done at %0t with no job in flight", $time);
			errors++;
		end else begin
			exp_r    = exp_q.pop_front();
			acc_edge = edge_q.pop_front();
			for (int n = 0; n < jac_types_pkg::LANES; n++) begin
				check_value(64'(result.el[n]), 64'(exp_r.el[n]),
					$sformatf("job %0d element %0d", done_count, n));
			end
			check_value(64'(en_edges - acc_edge), 64'(jac_ctrl_pkg::LATENCY),
				$sformatf("job %0d latency", done_count));
		end
		done_count++;
	endtask

	// one clock; the model follows the same edge the DUT sees.
	task automatic run_cycle(input logic en_v, input logic start_v,
		input jac_types_pkg::mat_elem_t a_v, input jac_types_pkg::mat_elem_t b_v,
		input jac_types_pkg::mat_elem_t w_v);
		logic take;
		en    = en_v;
		start = start_v;
		a     = a_v;
		b     = b_v;
		w     = w_v;
		@(posedge clk);
		#0.5;
		if (en_v) begin
			en_edges++;
			take = start_v && (pending <= 1); // idle, or issuing the last step.
			if (pending > 0) begin
				pending--;
			end
			if (take) begin
				pending = jac_ctrl_pkg::STEPS;
				exp_q.push_back(model_result(a_v, b_v, w_v));
				edge_q.push_back(en_edges);
				accepted++;
			end
			if (done) begin
				check_done();
			end
		end
	endtask

	task automatic drain(input int en_low_pct, input string name);
		int waited;
		waited = 0;
		while (exp_q.size() != 0 && waited < 100) begin
			run_cycle(pick_en(en_low_pct), 1'b0, a, b, w);
			waited++;
		end
		if (exp_q.size() != 0) begin
			$display("timeout in %s: %0d jobs never signalled done", name, exp_q.size());
			errors++;
			exp_q.delete();
			edge_q.delete();
		end
	endtask

	task automatic report_test(input string name);
		if (errors == err_base) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: %0d errors", name, errors - err_base);
		end
		err_base = errors;
	endtask

	initial begin
		int dones;
		int taken;
		int tries;
		int gap;
		rst_n = 1'b0;
		en    = 1'b1;
		start = 1'b0;
		a     = '0;
		b     = '0;
		w     = '0;
		repeat (2) @(posedge clk);
		#0.5;
		rst_n = 1'b1;

		for (int i = 0; i < 10; i++) begin
			run_cycle(1'b1, 1'b0, a, b, w);
			check_value(64'(done), 64'sd0, "done after reset");
		end
		report_test("after reset");

		for (int j = 0; j < 10; j++) begin
			pick_job();
			if (j == 0) begin
				job_a = fill_mat(-256);
				job_b = fill_mat(-256);
				job_w = fill_mat(-256);
			end else if (j == 1) begin
				job_a = fill_mat(255);
				job_b = fill_mat(255);
				job_w = fill_mat(255);
			end else if (j == 2) begin
				job_a = fill_mat(-256); // largest negative sum.
				job_b = fill_mat(255);
				job_w = fill_mat(-256);
			end
			run_cycle(1'b1, 1'b1, job_a, job_b, job_w);
			drain(0, "single job");
		end
		report_test("single job");

		dones = done_count;
		for (int j = 0; j < 20; j++) begin
			pick_job();
			run_cycle(1'b1, 1'b1, job_a, job_b, job_w);
			run_cycle(1'b1, 1'b0, job_a, job_b, job_w);
			run_cycle(1'b1, 1'b0, job_a, job_b, job_w);
		end
		drain(0, "back-to-back");
		check_value(64'(done_count - dones), 64'sd20, "back-to-back done count");
		report_test("back-to-back");

		// new data on every raised start, so a wrongly taken one shows up.
		dones = done_count;
		taken = accepted;
		for (int j = 0; j < 12; j++) begin
			for (int s = 0; s < 3; s++) begin
				pick_job();
				run_cycle(1'b1, 1'b1, job_a, job_b, job_w);
			end
			gap = rand_below(3);
			for (int g = 0; g < gap; g++) begin
				run_cycle(1'b1, 1'b0, job_a, job_b, job_w);
			end
		end
		drain(0, "ignored starts");
		check_value(64'(done_count - dones), 64'(accepted - taken), "ignored starts done count");
		report_test("ignored starts");

		dones = done_count;
		for (int j = 0; j < 50; j++) begin
			pick_job();
			taken = accepted;
			tries = 0;
			while (accepted == taken && tries < 40) begin
				run_cycle(pick_en(30), 1'b1, job_a, job_b, job_w);
				tries++;
			end
			if (accepted == taken) begin
				$display("timeout: job %0d of the enable test was never accepted", j);
				errors++;
			end
			gap = rand_below(4);
			for (int g = 0; g < gap; g++) begin
				run_cycle(pick_en(30), 1'b0, job_a, job_b, job_w);
			end
		end
		drain(30, "enable stalls");
		check_value(64'(done_count - dones), 64'sd50, "enable stalls done count");
		report_test("enable stalls");

		$display("checks: %0d, errors: %0d, jobs done: %0d", checks, errors, done_count);
		if (errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+tb
source/jac_types_pkg.sv
source/jac_ctrl_pkg.sv
source/mult_array.sv
source/jacobian_ctrl.sv
source/mat_mult.sv
source/array_mult.sv
source/jacobian_top.sv
tb/jacobian_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
	-f vlog.f \
	--top-module jacobian_tb \
	-Mdir obj_dir

./obj_dir/Vjacobian_tb | tee sim.log

if grep -q "tests failed" sim.log; then
	echo "simulation reported failures, see sim.log"
	exit 1
fi

echo "simulation finished without failures"
